// File: common/vgen_pkg.sv
package vgen_pkg;

    typedef logic [15:0] word_t;        // register data word
    typedef logic [7:0]  color_t;       // palette colour index
    typedef logic [10:0] hres_t;        // horizontal pixel counter
    typedef logic [9:0]  vres_t;        // vertical line counter

    typedef enum logic [1:0] {
        STATE_VISIBLE   = 2'b00,
        STATE_PRE_SYNC  = 2'b01,
        STATE_SYNC      = 2'b10,
        STATE_POST_SYNC = 2'b11
    } video_state_t;

    typedef struct packed {
        color_t         border_color;   // upper byte
        logic [3:0]     unused;
        logic [3:0]     intr;           // interrupt bits
    } vid_ctrl_t;

    typedef struct packed {
        color_t         colorbase;      // playfield colour
        logic           blank;
        logic           bitmap;
        logic [1:0]     bpp;
        logic [1:0]     h_repeat;
        logic [1:0]     v_repeat;
    } gfx_ctrl_t;

    // the same register word seen as either control layout
    typedef union packed {
        vid_ctrl_t      vid;
        gfx_ctrl_t      gfx;
    } xr_data_u;

    localparam logic [4:0] XR_VID_CTRL    = 5'h00;
    localparam logic [4:0] XR_SCANLINE    = 5'h01;
    localparam logic [4:0] XR_VID_LEFT    = 5'h02;
    localparam logic [4:0] XR_VID_RIGHT   = 5'h03;
    localparam logic [4:0] XR_VID_HSIZE   = 5'h04;
    localparam logic [4:0] XR_VID_VSIZE   = 5'h05;
    localparam logic [4:0] XR_PA_GFX_CTRL = 5'h10;

    localparam color_t BORDER_RESET = 8'h08;   // dark grey so a live raster is visible

    localparam logic H_SYNC_POLARITY = 1'b0;    // active level, VGA is negative
    localparam logic V_SYNC_POLARITY = 1'b0;

endpackage

// File: common/vgen_cfg_if.sv
`timescale 1ns/1ps

interface vgen_cfg_if;

    vgen_pkg::color_t   border_color;
    vgen_pkg::hres_t    vid_left;       // first pixel inside the window
    vgen_pkg::hres_t    vid_right;      // first pixel past the window
    vgen_pkg::color_t   pa_colorbase;
    logic               pa_blank;
    logic               pa_bitmap;      // stored only
    logic [1:0]         pa_bpp;         // stored only
    logic [1:0]         pa_h_repeat;    // stored only
    logic [1:0]         pa_v_repeat;    // stored only

    modport regs (output border_color, vid_left, vid_right, pa_colorbase, pa_blank,
                  pa_bitmap, pa_bpp, pa_h_repeat, pa_v_repeat);

    modport out (input border_color, vid_left, vid_right, pa_colorbase, pa_blank);

    modport rd (input border_color, vid_left, vid_right, pa_colorbase, pa_blank,
                pa_bitmap, pa_bpp, pa_h_repeat, pa_v_repeat);

endinterface

// File: common/scan_if.sv
`timescale 1ns/1ps

interface scan_if;

    // all values describe the pixel that is about to be shown
    vgen_pkg::hres_t    h_count;
    vgen_pkg::vres_t    v_count;
    logic               hsync;
    logic               vsync;
    logic               display_ena;
    logic               v_blank;
    logic               vblank_start;   // single cycle, end of last visible pixel

    modport timing (output h_count, v_count, hsync, vsync, display_ena, v_blank,
                    vblank_start);

    modport out (input h_count, hsync, vsync, display_ena);

    modport rd (input v_count, v_blank);

    modport regs (input vblank_start);

endinterface

// File: rtl/xr_regs.sv
`timescale 1ns/1ps

module xr_regs #(
    parameter int H_VISIBLE = 640
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                xr_wr_en_i,         // register write strobe
    input  logic [4:0]          xr_reg_num_i,
    input  vgen_pkg::word_t     xr_data_i,
    output logic [3:0]          intr_signal_o,      // one cycle interrupt pulses
    vgen_cfg_if.regs            cfg,
    scan_if.regs                scan
);

    vgen_pkg::xr_data_u wr_data;

    assign wr_data = xr_data_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o       <= 4'b0;
            cfg.border_color    <= vgen_pkg::BORDER_RESET;
            cfg.vid_left        <= '0;
            cfg.vid_right       <= vgen_pkg::hres_t'(H_VISIBLE);  // full width window
            cfg.pa_colorbase    <= '0;
            cfg.pa_blank        <= 1'b1;                // playfield starts blanked
            cfg.pa_bitmap       <= 1'b0;
            cfg.pa_bpp          <= 2'b0;
            cfg.pa_h_repeat     <= 2'b0;
            cfg.pa_v_repeat     <= 2'b0;
        end else begin
            intr_signal_o <= 4'b0;                      // pulses last one cycle

            if (xr_wr_en_i) begin
                case (xr_reg_num_i)
                    vgen_pkg::XR_VID_CTRL: begin
                        cfg.border_color    <= wr_data.vid.border_color;
                        intr_signal_o       <= wr_data.vid.intr;   // software interrupt
                    end
                    vgen_pkg::XR_VID_LEFT: begin
                        cfg.vid_left        <= xr_data_i[10:0];
                    end
                    vgen_pkg::XR_VID_RIGHT: begin
                        cfg.vid_right       <= xr_data_i[10:0];
                    end
                    vgen_pkg::XR_PA_GFX_CTRL: begin
                        cfg.pa_colorbase    <= wr_data.gfx.colorbase;
                        cfg.pa_blank        <= wr_data.gfx.blank;
                        cfg.pa_bitmap       <= wr_data.gfx.bitmap;
                        cfg.pa_bpp          <= wr_data.gfx.bpp;
                        cfg.pa_h_repeat     <= wr_data.gfx.h_repeat;
                        cfg.pa_v_repeat     <= wr_data.gfx.v_repeat;
                    end
                    default: begin
                    end
                endcase
            end

            // the vblank interrupt can coincide with a control write
            if (scan.vblank_start) begin
                intr_signal_o[3] <= 1'b1;
            end
        end
    end

endmodule

// File: video_timing/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  logic    clk,
    input  logic    reset_i,
    scan_if.timing  scan
);

    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    vgen_pkg::video_state_t h_state, h_state_next;
    vgen_pkg::video_state_t v_state, v_state_next;
    vgen_pkg::hres_t        h_count, h_count_next, h_end;
    vgen_pkg::vres_t        v_count, v_count_next, v_end;
    logic                   h_line_last_pixel;
    logic                   h_vis_last_pixel;
    logic                   last_frame_pixel;

    always_comb begin
        case (h_state)      // visible pixels come first on a line
            vgen_pkg::STATE_VISIBLE:  h_end = vgen_pkg::hres_t'(H_VISIBLE - 1);
            vgen_pkg::STATE_PRE_SYNC: h_end = vgen_pkg::hres_t'(H_VISIBLE + H_FRONT - 1);
            vgen_pkg::STATE_SYNC:     h_end = vgen_pkg::hres_t'(H_TOTAL - H_BACK - 1);
            default:                  h_end = vgen_pkg::hres_t'(H_TOTAL - 1);
        endcase
        case (v_state)
            vgen_pkg::STATE_VISIBLE:  v_end = vgen_pkg::vres_t'(V_VISIBLE - 1);
            vgen_pkg::STATE_PRE_SYNC: v_end = vgen_pkg::vres_t'(V_VISIBLE + V_FRONT - 1);
            vgen_pkg::STATE_SYNC:     v_end = vgen_pkg::vres_t'(V_TOTAL - V_BACK - 1);
            default:                  v_end = vgen_pkg::vres_t'(V_TOTAL - 1);
        endcase
    end

    assign h_state_next = (h_count == h_end) ? vgen_pkg::video_state_t'(h_state + 2'd1)
                                             : h_state;
    assign h_line_last_pixel = (h_state == vgen_pkg::STATE_POST_SYNC)
                            && (h_state_next == vgen_pkg::STATE_VISIBLE);
    assign h_vis_last_pixel  = (h_state == vgen_pkg::STATE_VISIBLE)
                            && (h_state_next == vgen_pkg::STATE_PRE_SYNC);

    // vertical state only moves at the end of a line
    assign v_state_next = (h_line_last_pixel && v_count == v_end)
                        ? vgen_pkg::video_state_t'(v_state + 2'd1) : v_state;
    assign last_frame_pixel = h_line_last_pixel && (v_state == vgen_pkg::STATE_POST_SYNC)
                           && (v_state_next == vgen_pkg::STATE_VISIBLE);

    always_comb begin
        h_count_next = h_count + 1'b1;
        v_count_next = v_count;
        if (h_line_last_pixel) begin
            h_count_next = '0;
            v_count_next = last_frame_pixel ? '0 : v_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= vgen_pkg::STATE_VISIBLE;
            v_state <= vgen_pkg::STATE_VISIBLE;
            h_count <= '0;
            v_count <= '0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            h_count <= h_count_next;
            v_count <= v_count_next;
        end
    end

    assign scan.h_count      = h_count_next;
    assign scan.v_count      = v_count_next;
    assign scan.hsync        = (h_state_next == vgen_pkg::STATE_SYNC);
    assign scan.vsync        = (v_state_next == vgen_pkg::STATE_SYNC);
    assign scan.display_ena  = (h_state_next == vgen_pkg::STATE_VISIBLE)
                            && (v_state_next == vgen_pkg::STATE_VISIBLE);
    assign scan.v_blank      = (v_state_next != vgen_pkg::STATE_VISIBLE);
    assign scan.vblank_start = h_vis_last_pixel && (v_state == vgen_pkg::STATE_VISIBLE)
                            && (v_count == vgen_pkg::vres_t'(V_VISIBLE - 1));

    a_h_range: assert property (@(posedge clk) disable iff (reset_i)
        int'(h_count) < H_TOTAL);
    a_v_range: assert property (@(posedge clk) disable iff (reset_i)
        int'(v_count) < V_TOTAL);
    a_sync_vs_de: assert property (@(posedge clk) disable iff (reset_i)
        !(scan.hsync && scan.display_ena));

endmodule

// File: rtl/video_output.sv
`timescale 1ns/1ps

module video_output (
    input  logic                clk,
    input  logic                reset_i,
    vgen_cfg_if.out             cfg,
    scan_if.out                 scan,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o,            // display enable for HDMI
    output vgen_pkg::color_t    color_index_o
);

    logic               in_window;
    vgen_pkg::color_t   pixel_color;

    assign in_window = (scan.h_count >= cfg.vid_left) && (scan.h_count < cfg.vid_right)
                    && !cfg.pa_blank;

    always_comb begin
        pixel_color = '0;                               // black outside display
        if (scan.display_ena) begin
            pixel_color = in_window ? cfg.pa_colorbase : cfg.border_color;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hsync_o         <= ~vgen_pkg::H_SYNC_POLARITY;   // inactive level
            vsync_o         <= ~vgen_pkg::V_SYNC_POLARITY;
            dv_de_o         <= 1'b0;
            color_index_o   <= '0;
        end else begin
            hsync_o         <= scan.hsync ? vgen_pkg::H_SYNC_POLARITY : ~vgen_pkg::H_SYNC_POLARITY;
            vsync_o         <= scan.vsync ? vgen_pkg::V_SYNC_POLARITY : ~vgen_pkg::V_SYNC_POLARITY;
            dv_de_o         <= scan.display_ena;
            color_index_o   <= pixel_color;
        end
    end

    a_blank_black: assert property (@(posedge clk) disable iff (reset_i)
        !dv_de_o |-> (color_index_o == '0));

endmodule

// File: rtl/xr_readback.sv
`timescale 1ns/1ps

module xr_readback #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
) (
    input  logic                clk,
    input  logic [4:0]          xr_reg_num_i,
    input  logic [3:0]          intr_status_i,      // pending interrupt bits
    vgen_cfg_if.rd              cfg,
    scan_if.rd                  scan,
    output vgen_pkg::word_t     xr_data_o
);

    vgen_pkg::xr_data_u packed_word;
    vgen_pkg::word_t    rd_data;

    always_comb begin
        packed_word = '0;
        rd_data     = '0;                               // unknown registers read zero
        case (xr_reg_num_i)
            vgen_pkg::XR_VID_CTRL: begin
                packed_word.vid.border_color = cfg.border_color;
                packed_word.vid.intr         = intr_status_i;
                rd_data = packed_word;
            end
            vgen_pkg::XR_SCANLINE:  rd_data = {scan.v_blank, 5'b0, scan.v_count};
            vgen_pkg::XR_VID_LEFT:  rd_data = {5'b0, cfg.vid_left};
            vgen_pkg::XR_VID_RIGHT: rd_data = {5'b0, cfg.vid_right};
            vgen_pkg::XR_VID_HSIZE: rd_data = 16'(H_VISIBLE);
            vgen_pkg::XR_VID_VSIZE: rd_data = 16'(V_VISIBLE);
            vgen_pkg::XR_PA_GFX_CTRL: begin
                packed_word.gfx = '{cfg.pa_colorbase, cfg.pa_blank, cfg.pa_bitmap, cfg.pa_bpp,
                                    cfg.pa_h_repeat, cfg.pa_v_repeat};
                rd_data = packed_word;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        xr_data_o <= rd_data;
    end

endmodule

// File: rtl/video_gen.sv
`timescale 1ns/1ps

module video_gen #(
    parameter int H_VISIBLE = 640,      // VGA 640x480 defaults
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  logic                clk,                // pixel clock
    input  logic                reset_i,
    input  logic                xr_wr_en_i,
    input  logic [4:0]          xr_reg_num_i,
    input  vgen_pkg::word_t     xr_data_i,
    output vgen_pkg::word_t     xr_data_o,
    input  logic [3:0]          intr_status_i,
    output logic [3:0]          intr_signal_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o,
    output vgen_pkg::color_t    color_index_o
);

    vgen_cfg_if cfg();
    scan_if     scan();

    xr_regs #(.H_VISIBLE(H_VISIBLE)) u_xr_regs (
        .clk(clk), .reset_i(reset_i), .xr_wr_en_i(xr_wr_en_i), .xr_reg_num_i(xr_reg_num_i),
        .xr_data_i(xr_data_i), .intr_signal_o(intr_signal_o), .cfg(cfg.regs), .scan(scan.regs)
    );

    video_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_video_timing (
        .clk(clk), .reset_i(reset_i), .scan(scan.timing)
    );

    video_output u_video_output (
        .clk(clk), .reset_i(reset_i), .cfg(cfg.out), .scan(scan.out), .hsync_o(hsync_o),
        .vsync_o(vsync_o), .dv_de_o(dv_de_o), .color_index_o(color_index_o)
    );

    xr_readback #(.H_VISIBLE(H_VISIBLE), .V_VISIBLE(V_VISIBLE)) u_xr_readback (
        .clk(clk), .xr_reg_num_i(xr_reg_num_i), .intr_status_i(intr_status_i),
        .cfg(cfg.rd), .scan(scan.rd), .xr_data_o(xr_data_o)
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk = ~clk;                             // free running, 50% duty
    end

endmodule

// File: tests/video_gen_tb.sv
`timescale 1ns/1ps

module video_gen_tb;

    localparam int H_VISIBLE = 16;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 3;
    localparam int H_BACK    = 3;
    localparam int V_VISIBLE = 8;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 1;
    localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT_CYCLES = 8 * FRAME_CYCLES + 500;
    localparam logic SYNC_ACTIVE  = 1'b0;           // VGA syncs are active low

    logic           clk;
    logic           reset_i;
    logic           xr_wr_en_i;
    logic [4:0]     xr_reg_num_i;
    logic [15:0]    xr_data_i;
    logic [15:0]    xr_data_o;
    logic [3:0]     intr_status_i;
    logic [3:0]     intr_signal_o;
    logic           hsync_o;
    logic           vsync_o;
    logic           dv_de_o;
    logic [7:0]     color_index_o;
    int             cycle_count = 0;
    int             error_count = 0;

    tb_clock #(.PERIOD_NS(100)) u_clock (.clk(clk));

    video_gen #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) UUT (
        .clk(clk), .reset_i(reset_i), .xr_wr_en_i(xr_wr_en_i), .xr_reg_num_i(xr_reg_num_i),
        .xr_data_i(xr_data_i), .xr_data_o(xr_data_o), .intr_status_i(intr_status_i),
        .intr_signal_o(intr_signal_o), .hsync_o(hsync_o), .vsync_o(vsync_o),
        .dv_de_o(dv_de_o), .color_index_o(color_index_o)
    );

    task automatic stop_on_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            stop_on_error($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            stop_on_error(what);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout: run went past %0d cycles", TIMEOUT_CYCLES));
        end
    end

    task automatic write_reg(input logic [4:0] num, input logic [15:0] data);
        @(posedge clk);
        xr_wr_en_i   <= 1'b1;
        xr_reg_num_i <= num;
        xr_data_i    <= data;
        @(posedge clk);
        xr_wr_en_i   <= 1'b0;                       // sampled by the DUT on this edge
    endtask

    task automatic read_reg(input logic [4:0] num, output logic [15:0] data);
        @(posedge clk);
        xr_reg_num_i <= num;
        @(posedge clk);
        @(negedge clk);
        data = xr_data_o;
    endtask

    // leaves the caller on the first sample after the vsync pulse
    task automatic wait_vsync_end();
        @(negedge clk);
        while (vsync_o != SYNC_ACTIVE) begin
            @(negedge clk);
        end
        while (vsync_o == SYNC_ACTIVE) begin
            @(negedge clk);
        end
    endtask

    task automatic test_reset_values();
        logic [15:0] rd;
        check_value("dv_de_o", int'(dv_de_o), 0);
        check_value("intr_signal_o", int'(intr_signal_o), 0);
        check_value("hsync_o", int'(hsync_o), int'(!SYNC_ACTIVE));
        check_value("vsync_o", int'(vsync_o), int'(!SYNC_ACTIVE));
        read_reg(vgen_pkg::XR_VID_CTRL, rd);
        check_value("xr_data_o VID_CTRL", int'(rd), int'({8'h08, 4'h0, intr_status_i}));
        read_reg(vgen_pkg::XR_VID_RIGHT, rd);
        check_value("xr_data_o VID_RIGHT", int'(rd), H_VISIBLE);
        read_reg(vgen_pkg::XR_VID_HSIZE, rd);
        check_value("xr_data_o VID_HSIZE", int'(rd), H_VISIBLE);
        read_reg(vgen_pkg::XR_VID_VSIZE, rd);
        check_value("xr_data_o VID_VSIZE", int'(rd), V_VISIBLE);
        read_reg(vgen_pkg::XR_PA_GFX_CTRL, rd);
        check_value("xr_data_o PA_GFX_CTRL", int'(rd), 16'h0080);   // only blank set
    endtask

    task automatic test_write_readback();
        logic [15:0] data;
        logic [15:0] rd;
        data = 16'($urandom());
        write_reg(vgen_pkg::XR_PA_GFX_CTRL, data);
        read_reg(vgen_pkg::XR_PA_GFX_CTRL, rd);
        check_value("xr_data_o PA_GFX_CTRL", int'(rd), int'(data));
        data = 16'($urandom());
        write_reg(vgen_pkg::XR_VID_LEFT, data);
        read_reg(vgen_pkg::XR_VID_LEFT, rd);
        check_value("xr_data_o VID_LEFT", int'(rd), int'({5'h0, data[10:0]}));
        data = 16'($urandom());
        write_reg(vgen_pkg::XR_VID_RIGHT, data);
        read_reg(vgen_pkg::XR_VID_RIGHT, rd);
        check_value("xr_data_o VID_RIGHT", int'(rd), int'({5'h0, data[10:0]}));
        data = 16'($urandom());
        write_reg(vgen_pkg::XR_VID_CTRL, data);
        read_reg(vgen_pkg::XR_VID_CTRL, rd);
        check_value("xr_data_o VID_CTRL", int'(rd), int'({data[15:8], 4'h0, intr_status_i}));
    endtask

    task automatic test_raster_timing();
        logic   act [3];
        logic   prev [3] = '{1'b0, 1'b0, 1'b0};
        int     len [3] = '{0, 0, 0};
        int     runs [3] = '{0, 0, 0};
        int     last [3] = '{0, 0, 0};
        int     width [3] = '{H_VISIBLE, H_SYNC, V_SYNC * H_TOTAL};
        int     period [3] = '{0, H_TOTAL, FRAME_CYCLES};    // display runs skip vblank
        int     count [3] = '{2 * V_VISIBLE, 2 * V_TOTAL, 2};
        string  name [3] = '{"dv_de_o", "hsync_o", "vsync_o"};
        wait_vsync_end();
        for (int i = 0; i <= 2 * FRAME_CYCLES; i++) begin
            act[0] = dv_de_o;
            act[1] = (hsync_o == SYNC_ACTIVE);
            act[2] = (vsync_o == SYNC_ACTIVE);
            for (int s = 0; s < 3; s++) begin
                if (act[s] && !prev[s]) begin
                    if (runs[s] > 0 && period[s] > 0) begin
                        check_value({name[s], " period"}, i - last[s], period[s]);
                    end
                    last[s] = i;
                    runs[s]++;
                end
                if (act[s]) begin
                    len[s]++;
                end else if (prev[s]) begin
                    check_value({name[s], " width"}, len[s], width[s]);
                    len[s] = 0;
                end
                prev[s] = act[s];
            end
            @(negedge clk);
        end
        for (int s = 0; s < 3; s++) begin
            check_value({name[s], " pulse count"}, runs[s], count[s]);
        end
    endtask

    task automatic test_color_window();
        logic [7:0] border;
        logic [7:0] base;
        logic [7:0] exp;
        int         pos;
        border = 8'($urandom());
        base   = ~border;                           // always distinct from the border
        write_reg(vgen_pkg::XR_VID_CTRL, {border, 8'h00});
        write_reg(vgen_pkg::XR_PA_GFX_CTRL, {base, 8'h00});
        write_reg(vgen_pkg::XR_VID_LEFT, 16'd4);
        write_reg(vgen_pkg::XR_VID_RIGHT, 16'd12);
        wait_vsync_end();
        pos = 0;
        repeat (FRAME_CYCLES) begin
            if (!dv_de_o) begin
                exp = 8'h00;
                pos = 0;
            end else begin
                exp = (pos < 4 || pos >= 12) ? border : base;
                pos++;
            end
            check_value("color_index_o", int'(color_index_o), int'(exp));
            @(negedge clk);
        end
    endtask

    task automatic test_interrupts();
        logic [3:0] bits;
        logic       de_prev = 1'b0;
        int         runs = 0;
        int         since_fall = FRAME_CYCLES;
        int         pulses = 0;
        bits = 4'($urandom());
        if (bits == 4'h0) begin
            bits = 4'h5;
        end
        write_reg(vgen_pkg::XR_VID_CTRL, {8'h08, 4'h0, bits});
        @(negedge clk);
        check_value("intr_signal_o", int'(intr_signal_o), int'(bits));
        @(negedge clk);
        check_value("intr_signal_o", int'(intr_signal_o), 0);
        repeat (FRAME_CYCLES) begin
            if (de_prev && !dv_de_o) begin
                runs++;
                since_fall = 0;
            end
            if (intr_signal_o != 4'h0) begin
                check_value("intr_signal_o", int'(intr_signal_o), 8);
                check_true(runs == V_VISIBLE && since_fall <= 1,
                           "vblank interrupt did not follow the last display run of the frame");
                pulses++;
            end
            since_fall++;
            de_prev = dv_de_o;
            @(negedge clk);
        end
        check_value("vblank interrupt count", pulses, 1);
    endtask

    task automatic test_scanline_readback();
        int line;
        int vs_reads = 0;
        int de_reads = 0;
        @(posedge clk);
        xr_reg_num_i <= vgen_pkg::XR_SCANLINE;
        @(posedge clk);
        @(negedge clk);
        repeat (FRAME_CYCLES) begin
            line = int'(xr_data_o[14:0]);
            if (vsync_o == SYNC_ACTIVE) begin
                check_value("xr_data_o[15]", int'(xr_data_o[15]), 1);
                check_true(line >= V_VISIBLE + V_FRONT && line < V_VISIBLE + V_FRONT + V_SYNC,
                           $sformatf("mismatch xr_data_o line: got 0x%0h expected 0x%0h to 0x%0h",
                                     line, V_VISIBLE + V_FRONT,
                                     V_VISIBLE + V_FRONT + V_SYNC - 1));
                vs_reads++;
            end
            if (dv_de_o) begin
                check_value("xr_data_o[15]", int'(xr_data_o[15]), 0);
                check_true(line < V_VISIBLE,
                           $sformatf("mismatch xr_data_o line: got 0x%0h expected below 0x%0h",
                                     line, V_VISIBLE));
                de_reads++;
            end
            @(negedge clk);
        end
        check_true(vs_reads > 0 && de_reads > 0, "scanline reads never saw vsync or display");
    endtask

    initial begin
        void'($urandom(32'haefd));
        reset_i       <= 1'b1;
        xr_wr_en_i    <= 1'b0;
        xr_reg_num_i  <= 5'h00;
        xr_data_i     <= 16'h0000;
        intr_status_i = 4'($urandom());             // pending bits seen on VID_CTRL reads
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        test_reset_values();
        test_write_readback();
        test_raster_timing();
        test_color_window();
        test_interrupts();
        test_scanline_readback();
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
common/vgen_pkg.sv
common/vgen_cfg_if.sv
common/scan_if.sv
rtl/xr_regs.sv
video_timing/video_timing.sv
rtl/video_output.sv
rtl/xr_readback.sv
rtl/video_gen.sv
tests/tb_clock.sv
tests/video_gen_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       := video_gen_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
